// File: spi_msg_pkg.sv
package spi_msg_pkg;

    // ======================================================================
    // Message framing
    // ======================================================================

    // Host to device message, type in the top byte
    localparam int unsigned msg_len      = 64;
    localparam int unsigned msg_type_len = 8;
    localparam int unsigned msg_arg_len  = msg_len - msg_type_len;

    // Device to host response, sent MSB first
    localparam int unsigned resp_len = 64;

    // Type bit that asks for a response
    localparam int unsigned resp_bit = 6;

    // ======================================================================
    // Opcodes
    // ======================================================================

    // Bit 7 is always set since the host cannot drive it
    typedef enum logic [msg_type_len-1:0] {
        msg_echo    = 8'hC0,
        msg_led_set = 8'h81,
        msg_nop     = 8'h82,
        msg_status  = 8'hC3
    } msg_type_e;

    // ======================================================================
    // Receiver states
    // ======================================================================

    typedef enum logic [1:0] {
        rx_dummy = 2'd0,
        rx_body  = 2'd1,
        rx_done  = 2'd2
    } rx_state_e;

    // ======================================================================
    // Status response layout
    // ======================================================================

    // Byte index counted from the MSB, byte 0 holds the echoed type
    localparam int unsigned resp_status_led_byte   = 1;
    localparam int unsigned resp_status_count_byte = 2;
    localparam int unsigned resp_status_bad_byte   = 3;

endpackage

// File: spi_msg_rx.sv
`timescale 1ns/1ps

module spi_msg_rx
    import spi_msg_pkg::*;
#(
    parameter int dummy_nibbles = 2,
    parameter int msg_nibbles   = 16
) (
    input  logic                   ice_st_spi_clk,
    input  logic                   spi_cs,
    input  logic [3:0]             spi_d_in,
    output logic                   msg_valid,
    output msg_type_e              msg_type,
    output logic [msg_arg_len-1:0] msg_arg
);

    // One counter serves both phases, sized for the longer one
    localparam int cnt_max = (msg_nibbles > dummy_nibbles) ? msg_nibbles : dummy_nibbles;
    localparam int cnt_w   = $clog2(cnt_max);

    localparam logic [cnt_w-1:0] last_dummy = cnt_w'(dummy_nibbles - 1);
    localparam logic [cnt_w-1:0] last_body  = cnt_w'(msg_nibbles - 1);

    rx_state_e          state_q;
    logic [cnt_w-1:0]   nib_cnt_q;
    logic [msg_len-1:0] shift_q;

    // ======================================================================
    // Framing FSM
    // ======================================================================

    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            state_q   <= rx_dummy;
            nib_cnt_q <= '0;
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= 1'b0;
            case (state_q)
                rx_dummy: begin
                    // First nibbles from the host are unreliable, drop them
                    if (nib_cnt_q == last_dummy) begin
                        nib_cnt_q <= '0;
                        state_q   <= rx_body;
                    end else begin
                        nib_cnt_q <= nib_cnt_q + 1'b1;
                    end
                end
                rx_body: begin
                    if (nib_cnt_q == last_body) begin
                        nib_cnt_q <= '0;
                        state_q   <= rx_done;
                        msg_valid <= 1'b1;
                    end else begin
                        nib_cnt_q <= nib_cnt_q + 1'b1;
                    end
                end
                default: begin
                    // Hold here until the host deselects us
                    state_q <= rx_done;
                end
            endcase
        end
    end

    // Message nibbles arrive MSB first
    always_ff @(posedge ice_st_spi_clk) begin
        if (state_q == rx_body) begin
            shift_q <= {shift_q[msg_len-5:0], spi_d_in};
        end
    end

    // Host can't send the top type bit, so fake it
    assign msg_type = msg_type_e'({1'b1, shift_q[msg_len-2 -: msg_type_len-1]});
    assign msg_arg  = shift_q[msg_arg_len-1:0];

endmodule

// File: spi_cmd_exec.sv
`timescale 1ns/1ps

module spi_cmd_exec
    import spi_msg_pkg::*;
#(
    parameter int led_width = 4
) (
    input  logic                   ice_st_spi_clk,
    input  logic                   spi_cs,
    input  logic                   msg_valid,
    input  msg_type_e              msg_type,
    input  logic [msg_arg_len-1:0] msg_arg,
    output logic [led_width-1:0]   ice_led,
    output logic                   resp_load,
    output logic [resp_len-1:0]    resp_word
);

    // These persist across transactions, chip select doesn't touch them
    logic [led_width-1:0] led_q       = '0;
    logic [7:0]           cmd_count_q = '0;
    logic [7:0]           bad_count_q = '0;

    logic                type_known;
    logic                is_led_set;
    logic [7:0]          led_byte;
    logic [resp_len-1:0] resp_next;

    assign led_byte   = 8'(led_q);
    assign is_led_set = (msg_type == msg_led_set);

    // ======================================================================
    // Decode and response assembly
    // ======================================================================

    always_comb begin
        type_known = 1'b1;
        resp_next  = '0;
        // Every response leads with the type byte
        resp_next[resp_len-1 -: msg_type_len] = msg_type;
        case (msg_type)
            msg_echo: begin
                resp_next[msg_arg_len-1:0] = msg_arg;
            end
            msg_status: begin
                // Counters reflect messages before this one
                resp_next[resp_len-1-8*resp_status_led_byte -: 8]   = led_byte;
                resp_next[resp_len-1-8*resp_status_count_byte -: 8] = cmd_count_q;
                resp_next[resp_len-1-8*resp_status_bad_byte -: 8]   = bad_count_q;
            end
            msg_led_set, msg_nop: begin
                // No response payload
            end
            default: begin
                type_known = 1'b0;
            end
        endcase
    end

    // ======================================================================
    // Command state
    // ======================================================================

    always_ff @(posedge ice_st_spi_clk) begin
        if (msg_valid) begin
            // Command count wraps at 256
            cmd_count_q <= cmd_count_q + 8'd1;
            if (!type_known) begin
                bad_count_q <= bad_count_q + 8'd1;
            end
            if (is_led_set) begin
                led_q <= msg_arg[led_width-1:0];
            end
            resp_word <= resp_next;
        end
    end

    // Only known types with the response bit get an answer
    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            resp_load <= 1'b0;
        end else begin
            resp_load <= msg_valid && type_known && msg_type[resp_bit];
        end
    end

    assign ice_led = led_q;

endmodule

// File: spi_resp_tx.sv
`timescale 1ns/1ps

module spi_resp_tx
    import spi_msg_pkg::*;
#(
    parameter int resp_bytes = 8
) (
    input  logic                ice_st_spi_clk,
    input  logic                spi_cs,
    input  logic                resp_load,
    input  logic [resp_len-1:0] resp_word,
    output logic [7:0]          spi_d_out,
    output logic                spi_d_oe
);

    localparam int cnt_w = $clog2(resp_bytes + 1);

    logic [resp_len-1:0] shift_q;
    logic [cnt_w-1:0]    bytes_left_q;

    // ======================================================================
    // Byte shifter
    // ======================================================================

    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            shift_q      <= '0;
            bytes_left_q <= '0;
            spi_d_oe     <= 1'b0;
        end else if (resp_load) begin
            // Top byte goes out on the same edge
            shift_q      <= resp_word;
            bytes_left_q <= cnt_w'(resp_bytes - 1);
            spi_d_oe     <= 1'b1;
        end else if (bytes_left_q != '0) begin
            shift_q      <= {shift_q[resp_len-9:0], 8'h00};
            bytes_left_q <= bytes_left_q - 1'b1;
        end else begin
            // Past the last byte the lines idle at zero
            shift_q <= '0;
        end
    end

    // Output enable stays up until deselect
    assign spi_d_out = shift_q[resp_len-1 -: 8];

endmodule

// File: ice_spi_top.sv
`timescale 1ns/1ps

module ice_spi_top
    import spi_msg_pkg::*;
#(
    parameter int dummy_nibbles = 2,
    parameter int msg_nibbles   = 16,
    parameter int led_width     = 4,
    parameter int resp_bytes    = 8
) (
    input  logic                 ice_st_spi_clk,
    input  logic                 spi_cs,
    input  logic [3:0]           spi_d_in,
    output logic [7:0]           spi_d_out,
    output logic                 spi_d_oe,
    output logic [led_width-1:0] ice_led
);

    // Receiver to executor
    logic                   msg_valid;
    msg_type_e              msg_type;
    logic [msg_arg_len-1:0] msg_arg;

    // Executor to transmitter
    logic                resp_load;
    logic [resp_len-1:0] resp_word;

    // ======================================================================
    // Message receive, 4 data lines in
    // ======================================================================

    spi_msg_rx #(
        .dummy_nibbles (dummy_nibbles),
        .msg_nibbles   (msg_nibbles)
    ) msg_rx_i (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .spi_d_in       (spi_d_in),
        .msg_valid      (msg_valid),
        .msg_type       (msg_type),
        .msg_arg        (msg_arg)
    );

    // ======================================================================
    // Command execution
    // ======================================================================

    spi_cmd_exec #(
        .led_width (led_width)
    ) cmd_exec_i (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .msg_valid      (msg_valid),
        .msg_type       (msg_type),
        .msg_arg        (msg_arg),
        .ice_led        (ice_led),
        .resp_load      (resp_load),
        .resp_word      (resp_word)
    );

    // ======================================================================
    // Response transmit, 8 data lines out
    // ======================================================================

    spi_resp_tx #(
        .resp_bytes (resp_bytes)
    ) resp_tx_i (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .resp_load      (resp_load),
        .resp_word      (resp_word),
        .spi_d_out      (spi_d_out),
        .spi_d_oe       (spi_d_oe)
    );

endmodule

// File: ice_spi_tb.sv
`timescale 1ns/1ps

module ice_spi_tb
    import spi_msg_pkg::*;
();

    localparam int cycle_ns     = 100;
    localparam int resp_timeout = 10;
    localparam int resp_latency = 2;
    localparam int quiet_cycles = 12;
    localparam int full_nibbles = 18;

    logic       ice_st_spi_clk = 1'b0;
    logic       spi_cs;
    logic [3:0] spi_d_in;
    logic [7:0] spi_d_out;
    logic       spi_d_oe;
    logic [3:0] ice_led;

    int seed      = 72;
    int errors    = 0;
    int tests_ok  = 0;
    int tests_bad = 0;

    // Host side copy of the device state
    logic [3:0] model_led       = '0;
    logic [7:0] model_cmd_count = '0;
    logic [7:0] model_bad_count = '0;

    always #(cycle_ns / 2) ice_st_spi_clk = ~ice_st_spi_clk;

    ice_spi_top #(
        .dummy_nibbles (2),
        .msg_nibbles   (16),
        .led_width     (4),
        .resp_bytes    (8)
    ) dut_i (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .spi_d_in       (spi_d_in),
        .spi_d_out      (spi_d_out),
        .spi_d_oe       (spi_d_oe),
        .ice_led        (ice_led)
    );

    // ======================================================================
    // Reference model
    // ======================================================================

    function automatic logic known_type(input logic [7:0] mtype);
        return (mtype == msg_echo) || (mtype == msg_led_set) ||
               (mtype == msg_nop) || (mtype == msg_status);
    endfunction

    // Response for a message, taken before the model counts it
    function automatic logic [63:0] expected_resp(input logic [7:0] mtype,
                                                  input logic [55:0] arg);
        logic [63:0] resp;
        resp = '0;
        resp[63:56] = mtype;
        if (mtype == msg_echo) begin
            resp[55:0] = arg;
        end else if (mtype == msg_status) begin
            resp[55:48] = {4'h0, model_led};
            resp[47:40] = model_cmd_count;
            resp[39:32] = model_bad_count;
        end
        return resp;
    endfunction

    function automatic void update_model(input logic [7:0] mtype, input logic [55:0] arg);
        model_cmd_count = model_cmd_count + 8'd1;
        if (!known_type(mtype)) begin
            model_bad_count = model_bad_count + 8'd1;
        end
        if (mtype == msg_led_set) begin
            model_led = arg[3:0];
        end
    endfunction

    // ======================================================================
    // Checking and host model
    // ======================================================================

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Error: time %0t, %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic rand_arg(output logic [55:0] arg);
        logic [31:0] hi;
        logic [31:0] lo;
        hi  = $random(seed);
        lo  = $random(seed);
        arg = {hi[23:0], lo};
    endtask

    // Dummy nibbles first, then the message MSB first
    task automatic send_msg(input logic [7:0] mtype, input logic [55:0] arg,
                            input int nibbles);
        logic [63:0] word;
        int i;
        word = {mtype, arg};
        // Host cannot drive the top type bit
        word[63] = 1'b0;
        for (i = 0; i < nibbles; i++) begin
            @(negedge ice_st_spi_clk);
            spi_cs = 1'b1;
            if (i < 2) begin
                spi_d_in = 4'hf;
            end else begin
                spi_d_in = word[63 - 4 * (i - 2) -: 4];
            end
        end
    endtask

    task automatic end_txn();
        @(negedge ice_st_spi_clk);
        spi_cs   = 1'b0;
        spi_d_in = 4'h0;
        @(negedge ice_st_spi_clk);
    endtask

    task automatic read_resp(output logic [63:0] resp);
        int waited;
        int b;
        logic seen;
        resp   = '0;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < resp_timeout) begin
            @(negedge ice_st_spi_clk);
            waited++;
            seen = spi_d_oe;
        end
        if (!seen) begin
            $display("Timeout: spi_d_oe did not rise within %0d cycles", resp_timeout);
            errors++;
        end else begin
            // Counted from the falling edge right after the last nibble
            check("response latency", resp_latency + 1, waited);
            for (b = 0; b < 8; b++) begin
                if (b > 0) begin
                    @(negedge ice_st_spi_clk);
                end
                resp = {resp[55:0], spi_d_out};
            end
        end
    endtask

    task automatic expect_quiet(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(negedge ice_st_spi_clk);
            check("spi_d_oe", 64'd0, spi_d_oe);
        end
    endtask

    // Full transaction that expects an answer
    task automatic resp_txn(input logic [7:0] mtype, input logic [55:0] arg);
        logic [63:0] expected;
        logic [63:0] actual;
        expected = expected_resp(mtype, arg);
        send_msg(mtype, arg, full_nibbles);
        read_resp(actual);
        check("response", expected, actual);
        // Lines idle at zero after the last byte
        @(negedge ice_st_spi_clk);
        check("spi_d_out", 64'd0, spi_d_out);
        check("spi_d_oe", 64'd1, spi_d_oe);
        update_model(mtype, arg);
        end_txn();
    endtask

    // Message with no answer, chip select left high
    task automatic quiet_txn(input logic [7:0] mtype, input logic [55:0] arg);
        send_msg(mtype, arg, full_nibbles);
        expect_quiet(quiet_cycles);
        update_model(mtype, arg);
    endtask

    task automatic finish_test(input int num, input string name, input int errs_at_start);
        if (errors == errs_at_start) begin
            tests_ok++;
            $display("Test %0d %s: ok", num, name);
        end else begin
            tests_bad++;
            $display("Test %0d %s: FAILED with %0d errors", num, name, errors - errs_at_start);
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin : main
        logic [55:0] arg;
        int start;
        int i;
        spi_cs   = 1'b0;
        spi_d_in = 4'h0;
        // Chip select rises on the next falling edge, two cycles low in all
        repeat (1) @(negedge ice_st_spi_clk);

        start = errors;
        for (i = 0; i < 10; i++) begin
            rand_arg(arg);
            resp_txn(msg_echo, arg);
        end
        finish_test(1, "echo", start);

        start = errors;
        rand_arg(arg);
        check("ice_led", model_led, ice_led);
        quiet_txn(msg_led_set, arg);
        check("ice_led", arg[3:0], ice_led);
        end_txn();
        // LED value outlives the transaction
        check("ice_led", arg[3:0], ice_led);
        finish_test(2, "led_set", start);

        start = errors;
        rand_arg(arg);
        resp_txn(msg_status, arg);
        finish_test(3, "status", start);

        start = errors;
        rand_arg(arg);
        quiet_txn(msg_nop, arg);
        end_txn();
        rand_arg(arg);
        quiet_txn(msg_led_set, arg);
        end_txn();
        check("ice_led", arg[3:0], ice_led);
        rand_arg(arg);
        resp_txn(msg_status, arg);
        finish_test(4, "no_response", start);

        start = errors;
        rand_arg(arg);
        quiet_txn(8'h85, arg);
        end_txn();
        rand_arg(arg);
        resp_txn(msg_status, arg);
        finish_test(5, "unknown_opcode", start);

        start = errors;
        rand_arg(arg);
        // Two dummies plus eight message nibbles, then deselect
        send_msg(msg_echo, arg, 10);
        expect_quiet(4);
        end_txn();
        rand_arg(arg);
        resp_txn(msg_echo, arg);
        rand_arg(arg);
        resp_txn(msg_status, arg);
        finish_test(6, "abort", start);

        $display("Tests passed: %0d, failed: %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: src.f
spi_msg_pkg.sv
spi_msg_rx.sv
spi_cmd_exec.sv
spi_resp_tx.sv
ice_spi_top.sv
ice_spi_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := ice_spi_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
